// File: Makefile
SIM        = verilator
TOP        = cpu_tb
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# a $fatal in the testbench gives a nonzero exit status
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/cpu_properties.sv
// Wishbone handshake properties of the core
// stb inside cyc, stable request until ack, idle bus in reset
`timescale 1ns/1ps

module cpu_properties (
    input logic        i_clk,
    input logic        i_rst_n,
    input logic        i_ack,
    input logic        i_cyc,
    input logic        i_stb,
    input logic        i_we,
    input logic [15:0] i_adr,
    input logic [7:0]  i_dat
);

    int unsigned fail_cnt = 0;

    stb_in_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n) i_stb |-> i_cyc)
        else
        begin
            $error("stb high outside a bus cycle");
            fail_cnt = fail_cnt + 1;
        end

    // request held until the slave acks
    req_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_stb && !i_ack) |=> (i_stb && $stable(i_adr) && $stable(i_we) && $stable(i_dat)))
        else
        begin
            $error("request changed before ack");
            fail_cnt = fail_cnt + 1;
        end

    idle_in_reset: assert property (@(posedge i_clk) !i_rst_n |-> (!i_cyc && !i_stb))
        else
        begin
            $error("cyc or stb high during reset");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind cpu_top cpu_properties u_props (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_ack   (i_wb_ack),
    .i_cyc   (o_wb_cyc),
    .i_stb   (o_wb_stb),
    .i_we    (o_wb_we),
    .i_adr   (o_wb_adr),
    .i_dat   (o_wb_dat)
);

// File: tests/cpu_tb.sv
// testbench for the core
// clock, reset, random-wait memory slave, random program
// instruction-level model with expected bus accesses, watchdog
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb;

    import cpu_pkg::*;

    localparam int NUM_INSTR = 200;
    localparam int RESET_ACCESSES = 6;
    // one request cycle plus up to four cycles until ack is sampled
    localparam int MAX_CLKS_PER_ACCESS = 5;
    localparam int TIMEOUT_CYCLES =
        (NUM_INSTR * 4 + RESET_ACCESSES) * MAX_CLKS_PER_ACCESS + 100;
    localparam logic [15:0] PROG_START = 16'h0200;
    localparam logic [7:0]  DATA_PAGE = 8'h40;

    typedef struct packed {
        logic [15:0] adr;
        logic        we;
        logic [7:0]  dat;
    } access_t;

    logic        clk;
    logic        rst_n;
    logic        wb_ack;
    logic [7:0]  wb_rdat;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [15:0] wb_adr;
    logic [7:0]  wb_wdat;

    logic [7:0]  mem [0:65535];
    access_t     exp_q [$];
    integer      seed = 23028;
    logic        all_done;
    logic        in_access;
    int unsigned wait_cnt;
    int unsigned wait_rnd;

    cpu_top dut0 (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_wb_dat (wb_rdat),
        .i_wb_ack (wb_ack),
        .o_wb_cyc (wb_cyc),
        .o_wb_stb (wb_stb),
        .o_wb_we  (wb_we),
        .o_wb_adr (wb_adr),
        .o_wb_dat (wb_wdat)
    );

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic add_expected(input logic [15:0] adr, input logic we, input logic [7:0] dat);
        access_t acc;
        acc.adr = adr;
        acc.we = we;
        acc.dat = dat;
        exp_q.push_back(acc);
    endtask

    function automatic logic [7:0] opcode_at(input int unsigned idx);
        case (idx)
        0: return OP_NOP;
        1: return OP_INX;
        2: return OP_INY;
        3: return OP_LDA_IMM;
        4: return OP_LDX_IMM;
        5: return OP_LDY_IMM;
        6: return OP_LDA_ABS;
        7: return OP_LDX_ABS;
        8: return OP_LDY_ABS;
        9: return OP_STA_ABS;
        10: return OP_STX_ABS;
        default: return OP_STY_ABS;
        endcase
    endfunction

    // program in memory plus the expected access list from the model
    task automatic build_program();
        logic [15:0] pc;
        logic [15:0] adr;
        logic [7:0]  op;
        logic [7:0]  lo;
        logic [7:0]  imm;
        logic [7:0]  a;
        logic [7:0]  x;
        logic [7:0]  y;
        logic [7:0]  data [0:255];
        int unsigned r;
        int          i;
        for (i = 0; i < 65536; i++)
        begin
            adr = i[15:0];
            mem[i] = adr[15:8] ^ adr[7:0] ^ 8'hA5;
        end
        for (i = 0; i < 256; i++)
        begin
            r = $random(seed);
            data[i] = r[7:0];
            mem[{DATA_PAGE, i[7:0]}] = r[7:0];
        end
        mem[`CPU_RESET_VECTOR] = PROG_START[7:0];
        mem[`CPU_RESET_VECTOR + 16'd1] = PROG_START[15:8];

        // reset runs as BRK with three stack reads
        add_expected(`CPU_PC_RESET, 1'b0, 8'h00);
        add_expected({`CPU_STACK_PAGE, `CPU_S_RESET}, 1'b0, 8'h00);
        add_expected({`CPU_STACK_PAGE, `CPU_S_RESET - 8'd1}, 1'b0, 8'h00);
        add_expected({`CPU_STACK_PAGE, `CPU_S_RESET - 8'd2}, 1'b0, 8'h00);
        add_expected(`CPU_RESET_VECTOR, 1'b0, 8'h00);
        add_expected(`CPU_RESET_VECTOR + 16'd1, 1'b0, 8'h00);

        // registers clear on reset
        a = 8'h00;
        x = 8'h00;
        y = 8'h00;
        pc = PROG_START;
        for (i = 0; i < NUM_INSTR; i++)
        begin
            r = $random(seed);
            op = opcode_at(r % 12);
            r = $random(seed);
            lo = r[7:0];
            // FF often enough to see INX and INY wrap
            imm = (r[9:8] == 2'b00) ? 8'hFF : r[7:0];
            mem[pc] = op;
            add_expected(pc, 1'b0, 8'h00);
            case (op)
            OP_NOP, OP_INX, OP_INY:
            begin
                add_expected(pc + 16'd1, 1'b0, 8'h00);
                if (op == OP_INX)
                    x = x + 8'd1;
                if (op == OP_INY)
                    y = y + 8'd1;
                pc = pc + 16'd1;
            end
            OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM:
            begin
                mem[pc + 16'd1] = imm;
                add_expected(pc + 16'd1, 1'b0, 8'h00);
                if (op == OP_LDA_IMM)
                    a = imm;
                else if (op == OP_LDX_IMM)
                    x = imm;
                else
                    y = imm;
                pc = pc + 16'd2;
            end
            default:
            begin
                mem[pc + 16'd1] = lo;
                mem[pc + 16'd2] = DATA_PAGE;
                add_expected(pc + 16'd1, 1'b0, 8'h00);
                add_expected(pc + 16'd2, 1'b0, 8'h00);
                case (op)
                OP_LDA_ABS: a = data[lo];
                OP_LDX_ABS: x = data[lo];
                OP_LDY_ABS: y = data[lo];
                OP_STA_ABS: data[lo] = a;
                OP_STX_ABS: data[lo] = x;
                default: data[lo] = y;
                endcase
                if (op == OP_STA_ABS || op == OP_STX_ABS || op == OP_STY_ABS)
                    add_expected({DATA_PAGE, lo}, 1'b1, data[lo]);
                else
                    add_expected({DATA_PAGE, lo}, 1'b0, 8'h00);
                pc = pc + 16'd3;
            end
            endcase
        end
    endtask

    task automatic check_access();
        access_t exp;
        exp = exp_q.pop_front();
        assert (wb_adr == exp.adr)
        else stop_run($sformatf("ERR o_wb_adr got %h expected %h", wb_adr, exp.adr));
        assert (wb_we == exp.we)
        else stop_run($sformatf("ERR o_wb_we got %h expected %h at adr %h",
                                wb_we, exp.we, exp.adr));
        if (exp.we)
        begin
            assert (wb_wdat == exp.dat)
            else stop_run($sformatf("ERR o_wb_dat got %h expected %h at adr %h",
                                    wb_wdat, exp.dat, exp.adr));
        end
        if (exp_q.size() == 0)
            all_done = 1'b1;
    endtask

    // accesses past the end of the program are served unchecked
    task automatic serve_access();
        if (!all_done)
            check_access();
        if (wb_we)
            mem[wb_adr] = wb_wdat;
        else
            wb_rdat = mem[wb_adr];
        wb_ack = 1'b1;
    endtask

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    // memory slave with 0 to 3 wait cycles per access
    initial
    begin
        wb_ack = 1'b0;
        wb_rdat = 8'h00;
        in_access = 1'b0;
        wait_cnt = 0;
        forever
        begin
            @(posedge clk);
            #1;
            if (wb_ack)
            begin
                wb_ack = 1'b0;
                in_access = 1'b0;
            end
            else if (wb_cyc && wb_stb)
            begin
                if (!in_access)
                begin
                    in_access = 1'b1;
                    wait_rnd = $random(seed);
                    wait_cnt = wait_rnd % 4;
                end
                if (wait_cnt == 0)
                    serve_access();
                else
                    wait_cnt = wait_cnt - 1;
            end
        end
    end

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        stop_run("simulation timed out waiting for bus accesses");
    end

    initial
    begin
        rst_n = 1'b0;
        all_done = 1'b0;
        build_program();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // last access completes on the edge after its ack is raised
        while (!all_done)
            @(posedge clk);
        if (dut0.u_props.fail_cnt != 0)
            stop_run("a Wishbone handshake property failed during the run");
        else
        begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// File: verilog.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/decoder.sv
verilog/timing_unit.sv
verilog/datapath.sv
verilog/wb_master.sv
verilog/cpu_top.sv
tests/cpu_properties.sv
tests/cpu_tb.sv

// File: verilog/cpu_defs.svh
// shared constants for the 6502-style core
// reset vector, stack page, reset values of S and PC, T-state counter width
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// reset vector low byte, high byte follows
`define CPU_RESET_VECTOR 16'hFFFC

// high byte of every stack address
`define CPU_STACK_PAGE 8'h01

// register values after reset
`define CPU_S_RESET  8'h00
`define CPU_PC_RESET 16'h0000

// T0 to T7
`define CPU_TCU_BITS 3

`endif

// File: verilog/cpu_pkg.sv
// opcode constants of the supported instruction set
// decode ROM control lines and the bus request
package cpu_pkg;

    localparam logic [7:0] OP_BRK     = 8'h00;
    localparam logic [7:0] OP_NOP     = 8'hEA;
    localparam logic [7:0] OP_INX     = 8'hE8;
    localparam logic [7:0] OP_INY     = 8'hC8;
    localparam logic [7:0] OP_LDA_IMM = 8'hA9;
    localparam logic [7:0] OP_LDX_IMM = 8'hA2;
    localparam logic [7:0] OP_LDY_IMM = 8'hA0;
    localparam logic [7:0] OP_LDA_ABS = 8'hAD;
    localparam logic [7:0] OP_LDX_ABS = 8'hAE;
    localparam logic [7:0] OP_LDY_ABS = 8'hAC;
    localparam logic [7:0] OP_STA_ABS = 8'h8D;
    localparam logic [7:0] OP_STX_ABS = 8'h8E;
    localparam logic [7:0] OP_STY_ABS = 8'h8C;

    // one bit per decode ROM line, rw high means read
    typedef struct packed {
        logic rw;
        // data latch outputs
        logic dl_db, dl_adl, dl_adh;
        // program counter
        logic pcl_pcl, adl_pcl, i_pc, pclc, pcl_adl, pcl_db;
        logic pch_pch, adh_pch, pch_adh, pch_db;
        // register and adder drivers
        logic x_sb, y_sb, ac_sb, ac_db, s_sb, s_adl;
        logic add_sb_7, add_sb_0_6, add_adl;
        // pull-downs on the address buses
        logic zero_adl0, zero_adl1, zero_adl2, zero_adh0, zero_adh1_7;
        // bus links and register loads
        logic sb_adh, sb_db, sb_x, sb_y, sb_ac, sb_s;
        logic adl_abl, adh_abh;
        // adder inputs and operation
        logic db_n_add, db_add, adl_add, zero_add, sb_add, one_addc, sums;
    } ctrl_t;

    typedef struct packed {
        logic [15:0] adr;
        logic [7:0]  dat;
        logic        we;
    } bus_req_t;

endpackage

// File: verilog/cpu_top.sv
// core top level
// timing unit, decoder, datapath and Wishbone master
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_top (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic [7:0]  i_wb_dat,
    input  logic        i_wb_ack,
    output logic        o_wb_cyc,
    output logic        o_wb_stb,
    output logic        o_wb_we,
    output logic [15:0] o_wb_adr,
    output logic [7:0]  o_wb_dat
);

    import cpu_pkg::*;

    logic [7:0]               ir;
    logic [`CPU_TCU_BITS-1:0] tcu;
    logic [`CPU_TCU_BITS-1:0] tcu_next;
    logic                     step;
    ctrl_t                    ctrl;
    bus_req_t                 req;

    timing_unit u_timing (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_step     (step),
        .i_tcu_next (tcu_next),
        .i_rdata    (i_wb_dat),
        .o_ir       (ir),
        .o_tcu      (tcu)
    );

    decoder u_decoder (
        .i_ir       (ir),
        .i_tcu      (tcu),
        .o_tcu_next (tcu_next),
        .o_ctrl     (ctrl)
    );

    datapath u_datapath (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_step  (step),
        .i_ctrl  (ctrl),
        .i_rdata (i_wb_dat),
        .o_req   (req)
    );

    wb_master u_wb (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_req    (req),
        .i_wb_ack (i_wb_ack),
        .o_wb_cyc (o_wb_cyc),
        .o_wb_stb (o_wb_stb),
        .o_wb_we  (o_wb_we),
        .o_wb_adr (o_wb_adr),
        .o_wb_dat (o_wb_dat),
        .o_step   (step)
    );

endmodule

// File: verilog/datapath.sv
// registers A, X, Y, S, program counter, adder and data latch
// internal buses ADL, ADH, SB and DB resolved from the control lines
// address and write data for the current T-state
`timescale 1ns/1ps
`include "cpu_defs.svh"

module datapath (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_step,
    input  cpu_pkg::ctrl_t    i_ctrl,
    input  logic [7:0]        i_rdata,
    output cpu_pkg::bus_req_t o_req
);

    logic [7:0] a_q, x_q, y_q, s_q;
    logic [7:0] pcl_q, pch_q;
    logic [7:0] add_q, dl_q;
    logic [7:0] abl_q, abh_q;

    logic [7:0] db_drv, sb_drv, adl_drv, adh_drv;
    logic [7:0] db_bus, sb_bus, adl_bus, adh_bus;
    logic [7:0] add_a, add_b, add_sum;
    logic [7:0] pcl_src, pch_src, pch_next;
    logic [8:0] pcl_next;
    logic [7:0] abl, abh;

    // drivers pull bits low, an idle bus stays precharged high
    always_comb
    begin
        db_drv = 8'hFF;
        if (i_ctrl.dl_db) db_drv &= dl_q;
        if (i_ctrl.pcl_db) db_drv &= pcl_q;
        if (i_ctrl.pch_db) db_drv &= pch_q;
        if (i_ctrl.ac_db) db_drv &= a_q;

        sb_drv = 8'hFF;
        if (i_ctrl.x_sb) sb_drv &= x_q;
        if (i_ctrl.y_sb) sb_drv &= y_q;
        if (i_ctrl.ac_sb) sb_drv &= a_q;
        if (i_ctrl.s_sb) sb_drv &= s_q;
        if (i_ctrl.add_sb_0_6) sb_drv &= {1'b1, add_q[6:0]};
        if (i_ctrl.add_sb_7) sb_drv &= {add_q[7], 7'h7F};

        adl_drv = 8'hFF;
        if (i_ctrl.dl_adl) adl_drv &= dl_q;
        if (i_ctrl.pcl_adl) adl_drv &= pcl_q;
        if (i_ctrl.s_adl) adl_drv &= s_q;
        if (i_ctrl.add_adl) adl_drv &= add_q;
        if (i_ctrl.zero_adl0) adl_drv &= 8'hFE;
        if (i_ctrl.zero_adl1) adl_drv &= 8'hFD;
        if (i_ctrl.zero_adl2) adl_drv &= 8'hFB;

        adh_drv = 8'hFF;
        if (i_ctrl.dl_adh) adh_drv &= dl_q;
        if (i_ctrl.pch_adh) adh_drv &= pch_q;
        if (i_ctrl.zero_adh0) adh_drv &= 8'hFE;
        if (i_ctrl.zero_adh1_7) adh_drv &= 8'h01;

        // pass transistors short SB to DB and ADH
        sb_bus = sb_drv;
        if (i_ctrl.sb_db) sb_bus &= db_drv;
        if (i_ctrl.sb_adh) sb_bus &= adh_drv;
        db_bus  = i_ctrl.sb_db ? sb_bus : db_drv;
        adh_bus = i_ctrl.sb_adh ? sb_bus : adh_drv;
        adl_bus = adl_drv;

        // adder A from SB or zero, B from DB, ~DB or ADL
        add_a = 8'hFF;
        if (i_ctrl.sb_add) add_a &= sb_bus;
        if (i_ctrl.zero_add) add_a = 8'h00;
        add_b = 8'hFF;
        if (i_ctrl.db_add) add_b &= db_bus;
        if (i_ctrl.db_n_add) add_b &= ~db_bus;
        if (i_ctrl.adl_add) add_b &= adl_bus;
        add_sum = add_a + add_b + {7'd0, i_ctrl.one_addc};

        // PC sources, increment ripples into PCH
        pcl_src = 8'hFF;
        if (i_ctrl.adl_pcl) pcl_src &= adl_bus;
        if (i_ctrl.pcl_pcl) pcl_src &= pcl_q;
        pch_src = 8'hFF;
        if (i_ctrl.adh_pch) pch_src &= adh_bus;
        if (i_ctrl.pch_pch) pch_src &= pch_q;
        pcl_next = {1'b0, pcl_src} + {8'd0, i_ctrl.i_pc};
        pch_next = pch_src + {7'd0, i_ctrl.pclc & pcl_next[8]};
    end

    // address latches hold when not loaded
    assign abl = i_ctrl.adl_abl ? adl_bus : abl_q;
    assign abh = i_ctrl.adh_abh ? adh_bus : abh_q;

    assign o_req = '{adr: {abh, abl}, dat: db_bus, we: ~i_ctrl.rw};

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            a_q <= 8'h00;
            x_q <= 8'h00;
            y_q <= 8'h00;
            s_q <= `CPU_S_RESET;
            {pch_q, pcl_q} <= `CPU_PC_RESET;
        end
        else if (i_step)
        begin
            if (i_ctrl.sb_ac) a_q <= sb_bus;
            if (i_ctrl.sb_x) x_q <= sb_bus;
            if (i_ctrl.sb_y) y_q <= sb_bus;
            if (i_ctrl.sb_s) s_q <= sb_bus;
            if (i_ctrl.adl_pcl | i_ctrl.pcl_pcl) pcl_q <= pcl_next[7:0];
            if (i_ctrl.adh_pch | i_ctrl.pch_pch) pch_q <= pch_next;
        end
    end

    // read data lands in DL at the end of every access
    always_ff @(posedge i_clk)
    begin
        if (i_step)
        begin
            dl_q  <= i_rdata;
            abl_q <= abl;
            abh_q <= abh;
            if (i_ctrl.sums)
                add_q <= add_sum;
        end
    end

endmodule

// File: verilog/decoder.sv
// decode ROM: opcode and T-state to control lines and next T-state
// helper functions for the fetch group and register bus selections
`timescale 1ns/1ps
`include "cpu_defs.svh"

module decoder (
    input  logic [7:0]               i_ir,
    input  logic [`CPU_TCU_BITS-1:0] i_tcu,
    output logic [`CPU_TCU_BITS-1:0] o_tcu_next,
    output cpu_pkg::ctrl_t           o_ctrl
);

    import cpu_pkg::*;

    // PC onto both address bus halves, PCL and PCH kept
    function automatic ctrl_t pc_to_ab(input ctrl_t c);
        ctrl_t r;
        r = c;
        r.pcl_adl = 1'b1;
        r.adl_abl = 1'b1;
        r.pch_adh = 1'b1;
        r.adh_abh = 1'b1;
        r.pcl_pcl = 1'b1;
        r.pch_pch = 1'b1;
        return r;
    endfunction

    // fetch group, PC out then incremented with carry into PCH
    function automatic ctrl_t fetch(input ctrl_t c);
        ctrl_t r;
        r = pc_to_ab(c);
        r.i_pc = 1'b1;
        r.pclc = 1'b1;
        return r;
    endfunction

    // SB into A, X or Y
    function automatic ctrl_t sb_to_reg(input ctrl_t c, input logic [7:0] op);
        ctrl_t r;
        r = c;
        case (op)
        OP_LDA_IMM, OP_LDA_ABS: r.sb_ac = 1'b1;
        OP_LDX_IMM, OP_LDX_ABS, OP_INX: r.sb_x = 1'b1;
        OP_LDY_IMM, OP_LDY_ABS, OP_INY: r.sb_y = 1'b1;
        default:
        begin
        end
        endcase
        return r;
    endfunction

    // store source onto DB, X and Y go through SB
    function automatic ctrl_t reg_to_db(input ctrl_t c, input logic [7:0] op);
        ctrl_t r;
        r = c;
        case (op)
        OP_STA_ABS: r.ac_db = 1'b1;
        OP_STX_ABS: r.x_sb = 1'b1;
        OP_STY_ABS: r.y_sb = 1'b1;
        default:
        begin
        end
        endcase
        r.sb_db = r.x_sb | r.y_sb;
        return r;
    endfunction

    always_comb
    begin
        o_ctrl = '0;
        o_ctrl.rw = 1'b1;
        o_tcu_next = i_tcu + 1'b1;

        case (i_tcu)
        0:
        begin
            if (i_ir == OP_BRK)
            begin
                // jump through the vector, high byte in DL and low byte in ADD
                o_ctrl.dl_adh = 1'b1;
                o_ctrl.adh_abh = 1'b1;
                o_ctrl.adh_pch = 1'b1;
                o_ctrl.add_adl = 1'b1;
                o_ctrl.adl_abl = 1'b1;
                o_ctrl.adl_pcl = 1'b1;
                o_ctrl.i_pc = 1'b1;
                o_ctrl.pclc = 1'b1;
            end
            else
                o_ctrl = fetch(o_ctrl);

            // previous instruction finishes during this fetch
            case (i_ir)
            OP_INX, OP_INY:
            begin
                o_ctrl.add_sb_0_6 = 1'b1;
                o_ctrl.add_sb_7 = 1'b1;
                o_ctrl = sb_to_reg(o_ctrl, i_ir);
            end
            OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_LDA_ABS, OP_LDX_ABS, OP_LDY_ABS:
            begin
                o_ctrl.dl_db = 1'b1;
                o_ctrl.sb_db = 1'b1;
                o_ctrl = sb_to_reg(o_ctrl, i_ir);
            end
            default:
            begin
            end
            endcase
        end
        1:
        begin
            case (i_ir)
            OP_BRK: o_ctrl = pc_to_ab(o_ctrl);
            OP_INX, OP_INY:
            begin
                // dummy read at PC while the adder forms reg + 1
                o_ctrl = pc_to_ab(o_ctrl);
                o_ctrl.x_sb = (i_ir == OP_INX);
                o_ctrl.y_sb = (i_ir == OP_INY);
                o_ctrl.sb_add = 1'b1;
                o_ctrl.db_n_add = 1'b1;
                o_ctrl.one_addc = 1'b1;
                o_ctrl.sums = 1'b1;
                o_tcu_next = '0;
            end
            OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM:
            begin
                o_ctrl = fetch(o_ctrl);
                o_tcu_next = '0;
            end
            OP_LDA_ABS, OP_LDX_ABS, OP_LDY_ABS, OP_STA_ABS, OP_STX_ABS, OP_STY_ABS:
                o_ctrl = fetch(o_ctrl);
            default:
            begin
                // NOP and anything unknown
                o_ctrl = pc_to_ab(o_ctrl);
                o_tcu_next = '0;
            end
            endcase
        end
        2:
        begin
            case (i_ir)
            OP_BRK:
            begin
                // stack read at 01,S and ADD = S - 1
                o_ctrl.s_adl = 1'b1;
                o_ctrl.adl_abl = 1'b1;
                o_ctrl.zero_adh1_7 = 1'b1;
                o_ctrl.adh_abh = 1'b1;
                o_ctrl.adl_add = 1'b1;
                o_ctrl.sb_add = 1'b1;
                o_ctrl.sums = 1'b1;
            end
            OP_LDA_ABS, OP_LDX_ABS, OP_LDY_ABS, OP_STA_ABS, OP_STX_ABS, OP_STY_ABS:
            begin
                // high byte fetch, low byte from DL parked in ADD
                o_ctrl = fetch(o_ctrl);
                o_ctrl.dl_db = 1'b1;
                o_ctrl.db_add = 1'b1;
                o_ctrl.zero_add = 1'b1;
                o_ctrl.sums = 1'b1;
            end
            default:
            begin
            end
            endcase
        end
        3:
        begin
            case (i_ir)
            OP_BRK:
            begin
                o_ctrl.add_adl = 1'b1;
                o_ctrl.adl_abl = 1'b1;
                o_ctrl.zero_adh1_7 = 1'b1;
                o_ctrl.adh_abh = 1'b1;
                o_ctrl.adl_add = 1'b1;
                o_ctrl.sb_add = 1'b1;
                o_ctrl.sums = 1'b1;
            end
            OP_LDA_ABS, OP_LDX_ABS, OP_LDY_ABS, OP_STA_ABS, OP_STX_ABS, OP_STY_ABS:
            begin
                // effective address DL:ADD
                o_ctrl.add_adl = 1'b1;
                o_ctrl.adl_abl = 1'b1;
                o_ctrl.dl_adh = 1'b1;
                o_ctrl.adh_abh = 1'b1;
                o_ctrl = reg_to_db(o_ctrl, i_ir);
                o_ctrl.rw = !(o_ctrl.ac_db | o_ctrl.sb_db);
                o_tcu_next = '0;
            end
            default:
            begin
            end
            endcase
        end
        4:
        begin
            if (i_ir == OP_BRK)
            begin
                // last stack read, S takes S - 2
                o_ctrl.add_adl = 1'b1;
                o_ctrl.adl_abl = 1'b1;
                o_ctrl.zero_adh1_7 = 1'b1;
                o_ctrl.adh_abh = 1'b1;
                o_ctrl.add_sb_0_6 = 1'b1;
                o_ctrl.add_sb_7 = 1'b1;
                o_ctrl.sb_s = 1'b1;
            end
        end
        5:
        begin
            if (i_ir == OP_BRK)
            begin
                // FFFC from precharged buses
                o_ctrl.adh_abh = 1'b1;
                o_ctrl.adl_abl = 1'b1;
                o_ctrl.zero_adl0 = 1'b1;
                o_ctrl.zero_adl1 = 1'b1;
            end
        end
        6:
        begin
            if (i_ir == OP_BRK)
            begin
                // FFFD, vector low byte moves from DL into ADD
                o_ctrl.adh_abh = 1'b1;
                o_ctrl.adl_abl = 1'b1;
                o_ctrl.zero_adl1 = 1'b1;
                o_ctrl.dl_db = 1'b1;
                o_ctrl.db_add = 1'b1;
                o_ctrl.zero_add = 1'b1;
                o_ctrl.sums = 1'b1;
                o_tcu_next = '0;
            end
        end
        default:
        begin
        end
        endcase
    end

endmodule

// File: verilog/timing_unit.sv
// instruction register and T-state counter
// both move only when a bus access completes
`timescale 1ns/1ps
`include "cpu_defs.svh"

module timing_unit (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_step,
    input  logic [`CPU_TCU_BITS-1:0] i_tcu_next,
    input  logic [7:0]               i_rdata,
    output logic [7:0]               o_ir,
    output logic [`CPU_TCU_BITS-1:0] o_tcu
);

    import cpu_pkg::*;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            // reset runs as BRK starting at T1
            o_ir  <= OP_BRK;
            o_tcu <= `CPU_TCU_BITS'(1);
        end
        else if (i_step)
        begin
            o_tcu <= i_tcu_next;
            // opcode arrives with the T0 read, old IR still finishes during T0
            if (o_tcu == '0)
                o_ir <= i_rdata;
        end
    end

endmodule

// File: verilog/wb_master.sv
// Wishbone classic master, one access per T-state
// request registered into the bus outputs, step pulse on ack
`timescale 1ns/1ps

module wb_master (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  cpu_pkg::bus_req_t i_req,
    input  logic              i_wb_ack,
    output logic              o_wb_cyc,
    output logic              o_wb_stb,
    output logic              o_wb_we,
    output logic [15:0]       o_wb_adr,
    output logic [7:0]        o_wb_dat,
    output logic              o_step
);

    localparam logic ST_REQ  = 1'b0;
    localparam logic ST_WAIT = 1'b1;

    logic state_q;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state_q <= ST_REQ;
            o_wb_we <= 1'b0;
        end
        else if (state_q == ST_REQ)
        begin
            state_q <= ST_WAIT;
            o_wb_we <= i_req.we;
        end
        else if (i_wb_ack)
        begin
            // idle for one cycle while the core steps
            state_q <= ST_REQ;
            o_wb_we <= 1'b0;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (state_q == ST_REQ)
        begin
            o_wb_adr <= i_req.adr;
            o_wb_dat <= i_req.dat;
        end
    end

    assign o_wb_cyc = (state_q == ST_WAIT);
    assign o_wb_stb = (state_q == ST_WAIT);
    assign o_step   = (state_q == ST_WAIT) && i_wb_ack;

endmodule
